// File: hw/sdp_rdma.sv
// read-DMA cluster top: register file, control and main/bias read engines
`timescale 1ns/1ns
`default_nettype none

module sdp_rdma
  import sdp_rdma_pkg::*;
#(
  parameter int DATA_W          = 64,
  parameter int MAX_OUTSTANDING = 4
) (
  input  wire               nvdla_core_clk,
  input  wire               nvdla_core_rstn,
  // apb
  input  wire               psel,
  input  wire               penable,
  input  wire               pwrite,
  input  wire [11:0]        paddr,
  input  wire [31:0]        pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  // main engine
  output logic              m_rd_req_valid,
  input  wire               m_rd_req_ready,
  output addr_t             m_rd_req_addr,
  input  wire               m_rd_rsp_valid,
  output logic              m_rd_rsp_ready,
  input  wire [DATA_W-1:0]  m_rd_rsp_data,
  output logic              m_out_valid,
  input  wire               m_out_ready,
  output logic [DATA_W-1:0] m_out_data,
  output logic              m_out_last,
  // bias engine
  output logic              b_rd_req_valid,
  input  wire               b_rd_req_ready,
  output addr_t             b_rd_req_addr,
  input  wire               b_rd_rsp_valid,
  output logic              b_rd_rsp_ready,
  input  wire [DATA_W-1:0]  b_rd_rsp_data,
  output logic              b_out_valid,
  input  wire               b_out_ready,
  output logic [DATA_W-1:0] b_out_data,
  output logic              b_out_last,
  output logic              done_intr
);

  logic op_en;
  logic flying_mode;
  logic bias_disable;
  logic op_done;

  sdp_rdma_cfg_if m_cfg_if ();
  sdp_rdma_cfg_if b_cfg_if ();

  // ==============================
  // registers and control

  sdp_rdma_reg u_reg (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .psel            (psel),
    .penable         (penable),
    .pwrite          (pwrite),
    .paddr           (paddr),
    .pwdata          (pwdata),
    .prdata          (prdata),
    .pready          (pready),
    .pslverr         (pslverr),
    .m_cfg           (m_cfg_if.regs),
    .b_cfg           (b_cfg_if.regs),
    .op_en           (op_en),
    .flying_mode     (flying_mode),
    .bias_disable    (bias_disable),
    .done            (op_done),
    .done_intr       (done_intr)
  );

  sdp_rdma_ctrl u_ctrl (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_en           (op_en),
    .flying_mode     (flying_mode),
    .bias_disable    (bias_disable),
    .m_cfg           (m_cfg_if.ctrl),
    .b_cfg           (b_cfg_if.ctrl),
    .done            (op_done)
  );

  // ==============================
  // read engines

  sdp_rdma_engine #(
    .DATA_W          (DATA_W),
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_mrdma (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg             (m_cfg_if.engine),
    .rd_req_valid    (m_rd_req_valid),
    .rd_req_ready    (m_rd_req_ready),
    .rd_req_addr     (m_rd_req_addr),
    .rd_rsp_valid    (m_rd_rsp_valid),
    .rd_rsp_ready    (m_rd_rsp_ready),
    .rd_rsp_data     (m_rd_rsp_data),
    .out_valid       (m_out_valid),
    .out_ready       (m_out_ready),
    .out_data        (m_out_data),
    .out_last        (m_out_last)
  );

  sdp_rdma_engine #(
    .DATA_W          (DATA_W),
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_brdma (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg             (b_cfg_if.engine),
    .rd_req_valid    (b_rd_req_valid),
    .rd_req_ready    (b_rd_req_ready),
    .rd_req_addr     (b_rd_req_addr),
    .rd_rsp_valid    (b_rd_rsp_valid),
    .rd_rsp_ready    (b_rd_rsp_ready),
    .rd_rsp_data     (b_rd_rsp_data),
    .out_valid       (b_out_valid),
    .out_ready       (b_out_ready),
    .out_data        (b_out_data),
    .out_last        (b_out_last)
  );

endmodule

`default_nettype wire

// File: hw/sdp_rdma_cfg_if.sv
// per-engine settings, start and done, with register, control and engine modports
`timescale 1ns/1ns
`default_nettype none

interface sdp_rdma_cfg_if
  import sdp_rdma_pkg::*;
();

  addr_t     base;
  addr_t     line_stride;
  addr_t     surf_stride;
  cube_dim_t width;
  cube_dim_t height;
  cube_dim_t channel;
  logic      op_en;   // level, held until engine done
  logic      done;    // one-cycle pulse

  modport regs (
    output base, line_stride, surf_stride, width, height, channel
  );

  modport ctrl (
    output op_en,
    input  done
  );

  modport engine (
    input  base, line_stride, surf_stride, width, height, channel, op_en,
    output done
  );

endinterface

`default_nettype wire

// File: hw/sdp_rdma_ctrl.sv
// done-pending flags, per-engine start gating and aggregate done
`timescale 1ns/1ns
`default_nettype none

module sdp_rdma_ctrl (
  input  wire            nvdla_core_clk,
  input  wire            nvdla_core_rstn,
  input  wire            op_en,
  input  wire            flying_mode,
  input  wire            bias_disable,
  sdp_rdma_cfg_if.ctrl   m_cfg,
  sdp_rdma_cfg_if.ctrl   b_cfg,
  output logic           done
);

  // bit 0 main engine, bit 1 bias engine
  logic [1:0] eng_done;
  logic [1:0] eng_dis;
  logic [1:0] pending;

  assign eng_done = {b_cfg.done, m_cfg.done};
  assign eng_dis  = {bias_disable, flying_mode};  // flying mode feeds the cube from outside

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      pending <= '0;
    end else if (done) begin
      pending <= '0;  // ready for next operation
    end else begin
      pending <= pending | eng_done;
    end
  end

  // an engine runs only once per operation
  assign m_cfg.op_en = op_en & ~pending[0] & ~eng_dis[0];
  assign b_cfg.op_en = op_en & ~pending[1] & ~eng_dis[1];

  assign done = op_en & (&(pending | eng_done | eng_dis));

endmodule

`default_nettype wire

// File: hw/sdp_rdma_engine.sv
// read engine: cube address walker, outstanding limiter, response stream and done
`timescale 1ns/1ns
`default_nettype none

module sdp_rdma_engine
  import sdp_rdma_pkg::*;
#(
  parameter int DATA_W          = 64,
  parameter int MAX_OUTSTANDING = 4
) (
  input  wire               nvdla_core_clk,
  input  wire               nvdla_core_rstn,
  sdp_rdma_cfg_if.engine    cfg,
  output logic              rd_req_valid,
  input  wire               rd_req_ready,
  output addr_t             rd_req_addr,
  input  wire               rd_rsp_valid,
  output logic              rd_rsp_ready,
  input  wire [DATA_W-1:0]  rd_rsp_data,
  output logic              out_valid,
  input  wire               out_ready,
  output logic [DATA_W-1:0] out_data,
  output logic              out_last
);

  localparam int OCW = $clog2(MAX_OUTSTANDING + 1);

  localparam logic [1:0] STEP_ATOM = 2'd0;
  localparam logic [1:0] STEP_LINE = 2'd1;
  localparam logic [1:0] STEP_SURF = 2'd2;
  localparam logic [1:0] STEP_END  = 2'd3;

  cube_dim_t      w_lim;
  cube_dim_t      h_lim;
  cube_dim_t      c_lim;
  logic           active;     // between start and last response
  logic           req_left;   // requests still to issue
  logic           done_r;
  logic           start;
  logic           req_fire;
  logic           rsp_fire;
  logic [1:0]     req_step;
  logic [1:0]     rsp_step;
  cube_dim_t      atom_cnt, line_cnt, surf_cnt;
  cube_dim_t      rsp_atom, rsp_line, rsp_surf;
  logic [OCW-1:0] out_cnt;
  addr_t          req_addr, line_addr, surf_addr;

  assign w_lim = cfg.width;
  assign h_lim = cfg.height;
  assign c_lim = cfg.channel;

  // which level of the atom/line/surface nest advances next
  function automatic logic [1:0] nest_step(cube_dim_t a, cube_dim_t l, cube_dim_t s);
    if (a != w_lim) return STEP_ATOM;
    else if (l != h_lim) return STEP_LINE;
    else if (s != c_lim) return STEP_SURF;
    else return STEP_END;
  endfunction

  assign start    = cfg.op_en & ~active & ~done_r;  // no restart in the done cycle
  assign req_fire = rd_req_valid & rd_req_ready;
  assign rsp_fire = rd_rsp_valid & out_ready;
  assign req_step = nest_step(atom_cnt, line_cnt, surf_cnt);
  assign rsp_step = nest_step(rsp_atom, rsp_line, rsp_surf);

  // ==============================
  // request side

  assign rd_req_valid = req_left & (out_cnt < OCW'(MAX_OUTSTANDING));
  assign rd_req_addr  = req_addr;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_left <= 1'b0;
      atom_cnt <= '0;
      line_cnt <= '0;
      surf_cnt <= '0;
    end else if (start) begin
      req_left <= 1'b1;
      atom_cnt <= '0;
      line_cnt <= '0;
      surf_cnt <= '0;
    end else if (req_fire) begin
      case (req_step)
        STEP_ATOM: atom_cnt <= atom_cnt + 1'b1;
        STEP_LINE: begin
          atom_cnt <= '0;
          line_cnt <= line_cnt + 1'b1;
        end
        STEP_SURF: begin
          atom_cnt <= '0;
          line_cnt <= '0;
          surf_cnt <= surf_cnt + 1'b1;
        end
        default: req_left <= 1'b0;  // last request accepted
      endcase
    end
  end

  // running addresses, no multipliers
  always_ff @(posedge nvdla_core_clk) begin
    if (start) begin
      req_addr  <= cfg.base & ATOM_MASK;
      line_addr <= cfg.base & ATOM_MASK;
      surf_addr <= cfg.base & ATOM_MASK;
    end else if (req_fire) begin
      case (req_step)
        STEP_ATOM: req_addr <= req_addr + addr_t'(ATOM_BYTES);
        STEP_LINE: begin
          line_addr <= line_addr + (cfg.line_stride & ATOM_MASK);
          req_addr  <= line_addr + (cfg.line_stride & ATOM_MASK);
        end
        STEP_SURF: begin
          surf_addr <= surf_addr + (cfg.surf_stride & ATOM_MASK);
          line_addr <= surf_addr + (cfg.surf_stride & ATOM_MASK);
          req_addr  <= surf_addr + (cfg.surf_stride & ATOM_MASK);
        end
        default: ;
      endcase
    end
  end

  // requests accepted minus responses accepted
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_cnt <= '0;
    end else begin
      case ({req_fire, rsp_fire})
        2'b10:   out_cnt <= out_cnt + 1'b1;
        2'b01:   out_cnt <= out_cnt - 1'b1;
        default: ;
      endcase
    end
  end

  // ==============================
  // response side

  assign rd_rsp_ready = out_ready;  // stream back-pressure stalls memory
  assign out_valid    = rd_rsp_valid;
  assign out_data     = rd_rsp_data;
  assign out_last     = rd_rsp_valid & active & (rsp_step == STEP_END);
  assign cfg.done     = done_r;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      active   <= 1'b0;
      done_r   <= 1'b0;
      rsp_atom <= '0;
      rsp_line <= '0;
      rsp_surf <= '0;
    end else begin
      done_r <= rsp_fire & active & (rsp_step == STEP_END);  // one-cycle pulse
      if (start) begin
        active   <= 1'b1;
        rsp_atom <= '0;
        rsp_line <= '0;
        rsp_surf <= '0;
      end else if (rsp_fire && active) begin
        case (rsp_step)
          STEP_ATOM: rsp_atom <= rsp_atom + 1'b1;
          STEP_LINE: begin
            rsp_atom <= '0;
            rsp_line <= rsp_line + 1'b1;
          end
          STEP_SURF: begin
            rsp_atom <= '0;
            rsp_line <= '0;
            rsp_surf <= rsp_surf + 1'b1;
          end
          default: active <= 1'b0;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/sdp_rdma_pkg.sv
// address and cube-dimension types, APB register map, read atom size
`default_nettype none

package sdp_rdma_pkg;

  typedef logic [31:0] addr_t;      // byte address, base or stride
  typedef logic [12:0] cube_dim_t;  // count minus one
  typedef logic [11:0] reg_addr_t;  // apb byte offset

  // one read request covers one atom
  localparam int    ATOM_BYTES = 32;
  localparam addr_t ATOM_MASK  = ~addr_t'(ATOM_BYTES - 1);  // clears low address bits

  // ==============================
  // register map

  localparam reg_addr_t REG_OP_EN           = 12'h000;  // bit 0 start / running
  localparam reg_addr_t REG_STATUS          = 12'h004;  // bit 0 done, w1c
  localparam reg_addr_t REG_MODE            = 12'h008;  // flying_mode, bias_disable
  localparam reg_addr_t REG_WIDTH           = 12'h00C;
  localparam reg_addr_t REG_HEIGHT          = 12'h010;
  localparam reg_addr_t REG_CHANNEL         = 12'h014;  // surfaces minus one

  // main engine
  localparam reg_addr_t REG_SRC_BASE        = 12'h018;
  localparam reg_addr_t REG_SRC_LINE_STRIDE = 12'h01C;
  localparam reg_addr_t REG_SRC_SURF_STRIDE = 12'h020;

  // bias engine
  localparam reg_addr_t REG_BS_BASE         = 12'h024;
  localparam reg_addr_t REG_BS_LINE_STRIDE  = 12'h028;
  localparam reg_addr_t REG_BS_SURF_STRIDE  = 12'h02C;

endpackage

`default_nettype wire

// File: hw/sdp_rdma_reg.sv
// APB register file: operation settings, self-clearing start, w1c done status
`timescale 1ns/1ns
`default_nettype none

module sdp_rdma_reg
  import sdp_rdma_pkg::*;
(
  input  wire            nvdla_core_clk,
  input  wire            nvdla_core_rstn,
  input  wire            psel,
  input  wire            penable,
  input  wire            pwrite,
  input  wire reg_addr_t paddr,
  input  wire [31:0]     pwdata,
  output logic [31:0]    prdata,
  output logic           pready,
  output logic           pslverr,
  sdp_rdma_cfg_if.regs   m_cfg,
  sdp_rdma_cfg_if.regs   b_cfg,
  output logic           op_en,
  output logic           flying_mode,
  output logic           bias_disable,
  input  wire            done,
  output logic           done_intr
);

  logic        wr_en;
  logic        addr_hit;
  logic [31:0] rd_data;
  logic        status_done;
  cube_dim_t   width_r;
  cube_dim_t   height_r;
  cube_dim_t   channel_r;
  addr_t       src_base;
  addr_t       src_line_stride;
  addr_t       src_surf_stride;
  addr_t       bs_base;
  addr_t       bs_line_stride;
  addr_t       bs_surf_stride;

  assign wr_en = psel & penable & pwrite;  // access cycle, no wait states

  // ==============================
  // register writes

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en           <= 1'b0;
      status_done     <= 1'b0;
      flying_mode     <= 1'b0;
      bias_disable    <= 1'b0;
      width_r         <= '0;
      height_r        <= '0;
      channel_r       <= '0;
      src_base        <= '0;
      src_line_stride <= '0;
      src_surf_stride <= '0;
      bs_base         <= '0;
      bs_line_stride  <= '0;
      bs_surf_stride  <= '0;
    end else begin
      if (done) begin
        op_en <= 1'b0;  // operation finished
      end else if (wr_en && paddr == REG_OP_EN && pwdata[0]) begin
        op_en <= 1'b1;
      end
      if (done) begin
        status_done <= 1'b1;  // set wins over clear
      end else if (wr_en && paddr == REG_STATUS && pwdata[0]) begin
        status_done <= 1'b0;
      end
      if (wr_en) begin
        case (paddr)
          REG_MODE: begin
            flying_mode  <= pwdata[0];
            bias_disable <= pwdata[1];
          end
          REG_WIDTH:           width_r         <= pwdata[12:0];
          REG_HEIGHT:          height_r        <= pwdata[12:0];
          REG_CHANNEL:         channel_r       <= pwdata[12:0];
          REG_SRC_BASE:        src_base        <= pwdata;
          REG_SRC_LINE_STRIDE: src_line_stride <= pwdata;
          REG_SRC_SURF_STRIDE: src_surf_stride <= pwdata;
          REG_BS_BASE:         bs_base         <= pwdata;
          REG_BS_LINE_STRIDE:  bs_line_stride  <= pwdata;
          REG_BS_SURF_STRIDE:  bs_surf_stride  <= pwdata;
          default: ;  // op_en and status handled above
        endcase
      end
    end
  end

  // ==============================
  // read decode

  always_comb begin
    rd_data  = '0;
    addr_hit = 1'b1;
    case (paddr)
      REG_OP_EN:           rd_data[0]   = op_en;
      REG_STATUS:          rd_data[0]   = status_done;
      REG_MODE:            rd_data[1:0] = {bias_disable, flying_mode};
      REG_WIDTH:           rd_data      = 32'(width_r);
      REG_HEIGHT:          rd_data      = 32'(height_r);
      REG_CHANNEL:         rd_data      = 32'(channel_r);
      REG_SRC_BASE:        rd_data      = src_base;
      REG_SRC_LINE_STRIDE: rd_data      = src_line_stride;
      REG_SRC_SURF_STRIDE: rd_data      = src_surf_stride;
      REG_BS_BASE:         rd_data      = bs_base;
      REG_BS_LINE_STRIDE:  rd_data      = bs_line_stride;
      REG_BS_SURF_STRIDE:  rd_data      = bs_surf_stride;
      default:             addr_hit     = 1'b0;
    endcase
  end

  assign prdata    = rd_data;
  assign pready    = 1'b1;
  assign pslverr   = psel & penable & ~addr_hit;
  assign done_intr = status_done;

  // shared cube geometry, per-engine addresses
  assign m_cfg.width       = width_r;
  assign m_cfg.height      = height_r;
  assign m_cfg.channel     = channel_r;
  assign m_cfg.base        = src_base;
  assign m_cfg.line_stride = src_line_stride;
  assign m_cfg.surf_stride = src_surf_stride;

  assign b_cfg.width       = width_r;
  assign b_cfg.height      = height_r;
  assign b_cfg.channel     = channel_r;
  assign b_cfg.base        = bs_base;
  assign b_cfg.line_stride = bs_line_stride;
  assign b_cfg.surf_stride = bs_surf_stride;

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# compile and run the read-DMA testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_sdp_rdma --Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/Vtb_sdp_rdma > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: test/tb_sdp_rdma.sv
// clock, reset, APB tasks, memory models, scoreboard, watchdog and directed tests
`timescale 1ns/1ns
`default_nettype none

module tb_sdp_rdma
  import sdp_rdma_pkg::*;
();

  localparam int          MAX_OUT  = 4;
  localparam logic [63:0] DATA_XOR = 64'h5a5a_0000_a5a5_ffff;
  localparam addr_t       LOW_MASK = 32'hffff_ffe0;  // low 5 bits ignored

  logic        clk = 1'b0;
  logic        rstn;
  logic        psel;
  logic        penable;
  logic        pwrite;
  reg_addr_t   paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        done_intr;

  // index 0 main engine, 1 bias engine
  logic        req_valid [2];
  logic        req_ready [2] = '{1'b0, 1'b0};
  addr_t       req_addr  [2];
  logic        rsp_valid [2] = '{1'b0, 1'b0};
  logic        rsp_ready [2];
  logic [63:0] rsp_data  [2] = '{64'h0, 64'h0};
  logic        out_valid [2];
  logic        out_ready [2] = '{1'b0, 1'b0};
  logic [63:0] out_data  [2];
  logic        out_last  [2];

  // cube and addresses as programmed
  cube_dim_t cw = '0;
  cube_dim_t ch = '0;
  cube_dim_t cc = '0;
  addr_t     base_r [2];
  addr_t     line_r [2];
  addr_t     surf_r [2];
  logic      req_on [2] = '{1'b0, 1'b0};
  logic      rand_mode  = 1'b0;
  string     pfx    [2] = '{"m", "b"};

  // memory model and scoreboard state
  logic [31:0] seed = 32'h2e228051;
  addr_t       fifo      [2][16];
  int          wr_ptr    [2] = '{0, 0};
  int          rd_ptr    [2] = '{0, 0};
  int          req_idx   [2] = '{0, 0};
  int          rsp_idx   [2] = '{0, 0};
  int          req_ofs   [2] = '{0, 0};
  int          rsp_ofs   [2] = '{0, 0};
  int          gap       [2] = '{0, 0};
  logic        hold_q    [2] = '{1'b0, 1'b0};
  addr_t       hold_addr [2];
  logic        done_seen = 1'b0;

  sdp_rdma #(.DATA_W(64), .MAX_OUTSTANDING(MAX_OUT)) dut0 (
    .nvdla_core_clk (clk),          .nvdla_core_rstn (rstn),
    .psel           (psel),         .penable         (penable),
    .pwrite         (pwrite),       .paddr           (paddr),
    .pwdata         (pwdata),       .prdata          (prdata),
    .pready         (pready),       .pslverr         (pslverr),
    .m_rd_req_valid (req_valid[0]), .m_rd_req_ready  (req_ready[0]),
    .m_rd_req_addr  (req_addr[0]),  .m_rd_rsp_valid  (rsp_valid[0]),
    .m_rd_rsp_ready (rsp_ready[0]), .m_rd_rsp_data   (rsp_data[0]),
    .m_out_valid    (out_valid[0]), .m_out_ready     (out_ready[0]),
    .m_out_data     (out_data[0]),  .m_out_last      (out_last[0]),
    .b_rd_req_valid (req_valid[1]), .b_rd_req_ready  (req_ready[1]),
    .b_rd_req_addr  (req_addr[1]),  .b_rd_rsp_valid  (rsp_valid[1]),
    .b_rd_rsp_ready (rsp_ready[1]), .b_rd_rsp_data   (rsp_data[1]),
    .b_out_valid    (out_valid[1]), .b_out_ready     (out_ready[1]),
    .b_out_data     (out_data[1]),  .b_out_last      (out_last[1]),
    .done_intr      (done_intr)
  );

  always #10 clk = ~clk;  // 20 ns period

  // ==============================
  // error reporting and helpers

  task automatic stop_on_error();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic describe_failure(input string what);
    $display("%0t: %s", $time, what);
    stop_on_error();
  endtask

  task automatic show_mismatch(input string name, input logic [63:0] exp, input logic [63:0] got);
    $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
    stop_on_error();
  endtask

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int cube_beats();
    return (int'(cw) + 1) * (int'(ch) + 1) * (int'(cc) + 1);
  endfunction

  // atom fastest, then line, then surface
  function automatic addr_t predicted_addr(input int e, input int k);
    int na;
    int nl;
    int a;
    int l;
    int s;
    na = int'(cw) + 1;
    nl = int'(ch) + 1;
    a  = k % na;
    l  = (k / na) % nl;
    s  = k / (na * nl);
    return (base_r[e] & LOW_MASK) + addr_t'(s) * (surf_r[e] & LOW_MASK)
         + addr_t'(l) * (line_r[e] & LOW_MASK) + addr_t'(a * ATOM_BYTES);
  endfunction

  function automatic logic [31:0] reg_pattern(input reg_addr_t a);
    return {a, 8'h5c, a} ^ 32'hc3a5_96e1;
  endfunction

  // ==============================
  // memory models and scoreboard

  always @(posedge clk) begin
    logic [31:0] r;
    addr_t       exp;
    int          idx;
    if (!rstn) begin
      for (int e = 0; e < 2; e++) begin
        rsp_valid[e] <= 1'b0;
        req_ready[e] <= 1'b0;
        out_ready[e] <= 1'b0;
      end
    end else begin
      if (done_intr && !done_seen) begin
        for (int e = 0; e < 2; e++) begin
          if (req_on[e]) begin
            assert (rsp_idx[e] - rsp_ofs[e] == cube_beats())
              else describe_failure({"done_intr rose before the last ", pfx[e], " beat"});
          end
        end
      end
      done_seen = done_intr;
      for (int e = 0; e < 2; e++) begin
        if (req_valid[e]) begin
          assert (req_on[e]) else describe_failure({pfx[e], " engine requested while not started"});
        end
        if (hold_q[e]) begin
          assert (req_valid[e]) else describe_failure({pfx[e], "_rd_req_valid dropped unaccepted"});
          assert (req_addr[e] == hold_addr[e])
            else show_mismatch({pfx[e], "_rd_req_addr"}, 64'(hold_addr[e]), 64'(req_addr[e]));
        end
        hold_q[e]    = req_valid[e] & ~req_ready[e];
        hold_addr[e] = req_addr[e];
        if (req_valid[e] && req_ready[e]) begin
          idx = req_idx[e] - req_ofs[e];
          exp = predicted_addr(e, idx);
          assert (req_idx[e] - rsp_idx[e] < MAX_OUT)
            else describe_failure({pfx[e], " engine exceeded the outstanding request limit"});
          assert (idx < cube_beats()) else describe_failure({pfx[e], " engine issued too many requests"});
          assert (req_addr[e] == exp)
            else show_mismatch({pfx[e], "_rd_req_addr"}, 64'(exp), 64'(req_addr[e]));
          fifo[e][wr_ptr[e] & 15] = req_addr[e];
          wr_ptr[e]  = wr_ptr[e] + 1;
          req_idx[e] = req_idx[e] + 1;
        end
        assert (rsp_ready[e] == out_ready[e])
          else show_mismatch({pfx[e], "_rd_rsp_ready"}, 64'(out_ready[e]), 64'(rsp_ready[e]));
        assert (out_valid[e] == rsp_valid[e])
          else show_mismatch({pfx[e], "_out_valid"}, 64'(rsp_valid[e]), 64'(out_valid[e]));
        if (rsp_valid[e] && rsp_ready[e]) begin
          idx = rsp_idx[e] - rsp_ofs[e];
          exp = predicted_addr(e, idx);
          assert (out_data[e] == ({32'h0, exp} ^ DATA_XOR))
            else show_mismatch({pfx[e], "_out_data"}, {32'h0, exp} ^ DATA_XOR, out_data[e]);
          assert (out_last[e] == (idx == cube_beats() - 1))
            else show_mismatch({pfx[e], "_out_last"}, 64'(idx == cube_beats() - 1),
                               64'(out_last[e]));
          rd_ptr[e]  = rd_ptr[e] + 1;
          rsp_idx[e] = rsp_idx[e] + 1;
        end
        r = lcg_next();
        req_ready[e] <= rand_mode ? (r[20] | r[21]) : 1'b1;  // ready 3 of 4 cycles
        out_ready[e] <= rand_mode ? (r[22] | r[23]) : 1'b1;
        if (!rsp_valid[e] || rsp_ready[e]) begin  // free to present next response
          if (rd_ptr[e] != wr_ptr[e] && gap[e] == 0) begin
            rsp_valid[e] <= 1'b1;
            rsp_data[e]  <= {32'h0, fifo[e][rd_ptr[e] & 15]} ^ DATA_XOR;
            gap[e] = rand_mode ? int'(r[26:25]) : 0;
          end else begin
            rsp_valid[e] <= 1'b0;
            if (gap[e] > 0) gap[e] = gap[e] - 1;
          end
        end
      end
    end
  end

  // ==============================
  // APB access

  task automatic apb_write(input reg_addr_t a, input logic [31:0] d, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= a;
    pwdata  <= d;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);  // access edge
    err = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input reg_addr_t a, output logic [31:0] d, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= a;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    assert (pready) else describe_failure("pready low during an access cycle");
    d   = prdata;
    err = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_ok(input reg_addr_t a, input logic [31:0] d);
    logic err;
    apb_write(a, d, err);
    assert (!err) else describe_failure($sformatf("pslverr on write to mapped offset 0x%03h", a));
  endtask

  task automatic read_expect(input reg_addr_t a, input logic [31:0] exp);
    logic [31:0] d;
    logic        err;
    apb_read(a, d, err);
    assert (!err) else describe_failure($sformatf("pslverr on read of mapped offset 0x%03h", a));
    assert (d == exp) else show_mismatch($sformatf("prdata[0x%03h]", a), 64'(exp), 64'(d));
  endtask

  // ==============================
  // operation helpers

  task automatic program_cube(input cube_dim_t w, input cube_dim_t h, input cube_dim_t c);
    cw = w;
    ch = h;
    cc = c;
    write_ok(REG_WIDTH, 32'(w));
    write_ok(REG_HEIGHT, 32'(h));
    write_ok(REG_CHANNEL, 32'(c));
  endtask

  task automatic program_engine(input int e, input addr_t base, input addr_t line, input addr_t surf);
    base_r[e] = base;
    line_r[e] = line;
    surf_r[e] = surf;
    write_ok(e == 0 ? REG_SRC_BASE : REG_BS_BASE, base);
    write_ok(e == 0 ? REG_SRC_LINE_STRIDE : REG_BS_LINE_STRIDE, line);
    write_ok(e == 0 ? REG_SRC_SURF_STRIDE : REG_BS_SURF_STRIDE, surf);
  endtask

  task automatic run_operation(input logic m_on, input logic b_on);
    int n;
    int exp_n;
    req_on[0] = m_on;
    req_on[1] = b_on;
    for (int e = 0; e < 2; e++) begin
      req_ofs[e] = req_idx[e];
      rsp_ofs[e] = rsp_idx[e];
    end
    write_ok(REG_OP_EN, 32'h1);
    read_expect(REG_OP_EN, 32'h1);  // still running
    n = 0;
    while (!done_intr && n < 5000) begin
      @(posedge clk);
      n = n + 1;
    end
    assert (done_intr) else describe_failure("done_intr did not rise at the end of the operation");
    for (int e = 0; e < 2; e++) begin
      exp_n = req_on[e] ? cube_beats() : 0;
      assert (req_idx[e] - req_ofs[e] == exp_n)
        else show_mismatch({pfx[e], " request count"}, 64'(exp_n), 64'(req_idx[e] - req_ofs[e]));
      assert (rsp_idx[e] - rsp_ofs[e] == exp_n)
        else show_mismatch({pfx[e], " beat count"}, 64'(exp_n), 64'(rsp_idx[e] - rsp_ofs[e]));
    end
    read_expect(REG_OP_EN, 32'h0);
    read_expect(REG_STATUS, 32'h1);
  endtask

  task automatic clear_status();
    write_ok(REG_STATUS, 32'h1);
    read_expect(REG_STATUS, 32'h0);
    assert (!done_intr) else show_mismatch("done_intr", 64'h0, 64'(done_intr));
  endtask

  // ==============================
  // directed tests

  task automatic test_register_access();
    reg_addr_t   offs  [10];
    logic [31:0] masks [10];
    logic [31:0] d;
    logic        err;
    offs  = '{REG_MODE, REG_WIDTH, REG_HEIGHT, REG_CHANNEL, REG_SRC_BASE, REG_SRC_LINE_STRIDE,
              REG_SRC_SURF_STRIDE, REG_BS_BASE, REG_BS_LINE_STRIDE, REG_BS_SURF_STRIDE};
    masks = '{32'h3, 32'h1fff, 32'h1fff, 32'h1fff, 32'hffff_ffff, 32'hffff_ffff,
              32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff};
    assert (!done_intr) else show_mismatch("done_intr", 64'h0, 64'(done_intr));
    assert (!req_valid[0] && !req_valid[1]) else describe_failure("rd_req_valid high after reset");
    read_expect(REG_OP_EN, 32'h0);
    read_expect(REG_STATUS, 32'h0);
    for (int i = 0; i < 10; i++) write_ok(offs[i], reg_pattern(offs[i]));
    for (int i = 0; i < 10; i++) read_expect(offs[i], reg_pattern(offs[i]) & masks[i]);
    apb_write(12'h030, 32'hffff_ffff, err);
    assert (err) else describe_failure("no pslverr on write to unmapped offset 0x030");
    apb_read(12'h030, d, err);
    assert (err) else describe_failure("no pslverr on read of unmapped offset 0x030");
    assert (d == 32'h0) else show_mismatch("prdata[0x030]", 64'h0, 64'(d));
    apb_read(12'hffc, d, err);
    assert (err) else describe_failure("no pslverr on read of unmapped offset 0xffc");
    assert (d == 32'h0) else show_mismatch("prdata[0xffc]", 64'h0, 64'(d));
  endtask

  task automatic test_main_only();
    rand_mode = 1'b0;
    write_ok(REG_MODE, 32'h2);                 // bias_disable
    program_cube(13'd3, 13'd1, 13'd2);         // 4 atoms, 2 lines, 3 surfaces
    program_engine(0, 32'h1000_0010, 32'h0000_0100, 32'h0000_041f);
    program_engine(1, 32'h2000_0000, 32'h0000_0100, 32'h0000_0400);
    run_operation(1'b1, 1'b0);
    clear_status();
  endtask

  task automatic test_both_random();
    rand_mode = 1'b1;
    write_ok(REG_MODE, 32'h0);
    program_cube(13'd5, 13'd2, 13'd1);
    program_engine(0, 32'h0004_0000, 32'h0000_0200, 32'h0000_1000);
    program_engine(1, 32'h0008_0007, 32'h0000_01ff, 32'h0000_0c40);
    run_operation(1'b1, 1'b1);
    clear_status();
  endtask

  task automatic test_flying_mode();
    rand_mode = 1'b0;
    write_ok(REG_MODE, 32'h1);                 // main engine off
    program_cube(13'd2, 13'd1, 13'd3);
    program_engine(1, 32'h0010_0040, 32'h0000_0080, 32'h0000_0300);
    run_operation(1'b0, 1'b1);                 // status left set
  endtask

  task automatic test_status_restart();
    assert (done_intr) else show_mismatch("done_intr", 64'h1, 64'(done_intr));
    clear_status();
    rand_mode = 1'b1;
    write_ok(REG_MODE, 32'h0);
    program_cube(13'd1, 13'd3, 13'd2);
    program_engine(0, 32'h3000_0000, 32'h0000_0040, 32'h0000_0400);
    program_engine(1, 32'h4000_0020, 32'h0000_0060, 32'h0000_0800);
    run_operation(1'b1, 1'b1);
    clear_status();
  endtask

  // ==============================
  // watchdog and sequence

  initial begin
    #200000;  // worst-case test lengths with margin
    describe_failure("watchdog expired before the tests finished");
  end

  initial begin
    rstn    <= 1'b0;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= '0;
    pwdata  <= '0;
    repeat (5) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);
    test_register_access();
    test_main_only();
    test_both_random();
    test_flying_mode();
    test_status_restart();
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
hw/sdp_rdma_pkg.sv
hw/sdp_rdma_cfg_if.sv
hw/sdp_rdma_reg.sv
hw/sdp_rdma_ctrl.sv
hw/sdp_rdma_engine.sv
hw/sdp_rdma.sv
test/tb_sdp_rdma.sv
